/* dv/tb_axi4_to_axi3_wr.sv */
`timescale 1ns/100ps
`default_nettype none

`include "axi_conv_consts.svh"

module tb_axi4_to_axi3_wr
  import axi_chan_pkg::*;
  import conv_cmd_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int TOTAL_BEATS  = 4 + 21 + 256 + 78;   // beats driven over all bursts.

  logic ACLK;
  logic ARESET;
  axi4_aw_t s_aw;
  logic s_aw_valid;
  logic s_aw_ready;
  axi4_w_t s_w;
  logic s_w_valid;
  logic s_w_ready;
  axi3_aw_t m_aw;
  logic m_aw_valid;
  logic m_aw_ready;
  axi3_w_t m_w;
  logic m_w_valid;
  logic m_w_ready;

  logic rand_ready;
  logic [31:0] data_ctr;
  axi4_aw_t burst_q[$];
  axi3_aw_t exp_aw_q[$];
  axi3_aw_t act_aw_q[$];
  axi3_w_t exp_w_q[$];
  axi3_w_t act_w_q[$];

  axi4_to_axi3_wr i_axi4_to_axi3_wr (
    .ACLK       (ACLK),
    .ARESET     (ARESET),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .s_w        (s_w),
    .s_w_valid  (s_w_valid),
    .s_w_ready  (s_w_ready),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_w        (m_w),
    .m_w_valid  (m_w_valid),
    .m_w_ready  (m_w_ready)
  );

  initial begin
    ACLK = 1'b0;
    forever #10 ACLK = ~ACLK;
  end

  initial begin
    m_aw_ready = 1'b1;
    m_w_ready  = 1'b1;
    forever begin
      @(negedge ACLK);
      if (rand_ready) begin
        m_aw_ready = ($urandom & 32'd1) != 0;
        m_w_ready  = ($urandom & 32'd1) != 0;
      end else begin
        m_aw_ready = 1'b1;
        m_w_ready  = 1'b1;
      end
    end
  end

  // both output channels are logged on every transfer.
  always @(posedge ACLK) begin
    if (!ARESET && m_aw_valid && m_aw_ready) act_aw_q.push_back(m_aw);
    if (!ARESET && m_w_valid && m_w_ready) act_w_q.push_back(m_w);
  end

  initial begin
    repeat (RESET_CYCLES + 200 * TOTAL_BEATS) @(posedge ACLK);
    $display("timeout: the run did not finish within its cycle budget");
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

  task automatic check_val(input logic [63:0] exp, input logic [63:0] act, input string msg);
    if (exp !== act) begin
      $display("[FAIL] %0t: %s, expected %0h, got %0h", $time, msg, exp, act);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  // AXI3 pieces of 16 beats, the last one taking what is left.
  task automatic add_expected(input axi4_aw_t aw);
    int n;
    int plen;
    axi3_aw_t piece;
    axi3_w_t beat;
    n = int'(aw.len) / 16 + 1;
    for (int k = 0; k < n; k++) begin
      plen = (k == n - 1) ? int'(aw.len) % 16 : 15;
      piece.id   = aw.id;
      piece.addr = aw.addr + 32'(k * 16 * `AXI_STRB_W);
      piece.len  = 4'(plen);
      exp_aw_q.push_back(piece);
      for (int b = 0; b <= plen; b++) begin
        beat.id   = aw.id;
        beat.data = data_ctr;
        beat.strb = data_ctr[`AXI_STRB_W-1:0];
        beat.last = (b == plen);
        exp_w_q.push_back(beat);
        data_ctr = data_ctr + 32'd1;
      end
    end
  endtask

  task automatic drive_aw();
    for (int i = 0; i < burst_q.size(); i++) begin
      @(negedge ACLK);
      s_aw       = burst_q[i];
      s_aw_valid = 1'b1;
      @(posedge ACLK);
      while (!s_aw_ready) @(posedge ACLK);
    end
    @(negedge ACLK);
    s_aw_valid = 1'b0;
  endtask

  task automatic drive_w(input logic [31:0] first_data);
    logic [31:0] d;
    d = first_data;
    for (int i = 0; i < burst_q.size(); i++) begin
      for (int b = 0; b <= int'(burst_q[i].len); b++) begin
        @(negedge ACLK);
        s_w.data  = d;
        s_w.strb  = d[`AXI_STRB_W-1:0];
        s_w.last  = (b == int'(burst_q[i].len));   // AXI4 last, unused by the DUT.
        s_w_valid = 1'b1;
        @(posedge ACLK);
        while (!s_w_ready) @(posedge ACLK);
        d = d + 32'd1;
      end
    end
    @(negedge ACLK);
    s_w_valid = 1'b0;
  endtask

  task automatic run_bursts(input string name);
    logic [31:0] first;
    exp_aw_q.delete();
    exp_w_q.delete();
    act_aw_q.delete();
    act_w_q.delete();
    first = data_ctr;
    foreach (burst_q[i]) add_expected(burst_q[i]);
    fork
      drive_aw();
      drive_w(first);
    join
    while (act_aw_q.size() < exp_aw_q.size() || act_w_q.size() < exp_w_q.size()) begin
      @(posedge ACLK);
    end
    repeat (4) @(posedge ACLK);   // let any extra transfer show up.
    check_val(64'(exp_aw_q.size()), 64'(act_aw_q.size()), {name, ": m_aw count"});
    check_val(64'(exp_w_q.size()), 64'(act_w_q.size()), {name, ": m_w count"});
    foreach (exp_aw_q[i]) begin
      check_val(64'(exp_aw_q[i]), 64'(act_aw_q[i]), $sformatf("%s: m_aw piece %0d", name, i));
    end
    foreach (exp_w_q[i]) begin
      check_val(64'(exp_w_q[i]), 64'(act_w_q[i]), $sformatf("%s: m_w beat %0d", name, i));
    end
  endtask

  // the first beat of the short burst is offered early, so an empty FIFO must block it.
  task automatic reset_state();
    s_w.data  = data_ctr;
    s_w.strb  = data_ctr[`AXI_STRB_W-1:0];
    s_w.last  = 1'b0;
    s_w_valid = 1'b1;
    @(posedge ACLK);
    check_val(64'(1'b1), 64'(s_aw_ready), "reset: s_aw_ready");
    check_val(64'(1'b0), 64'(m_aw_valid), "reset: m_aw_valid");
    check_val(64'(1'b0), 64'(m_w_valid), "reset: m_w_valid");
    check_val(64'(1'b0), 64'(s_w_ready), "reset: s_w_ready");
  endtask

  task automatic short_burst();
    burst_q = '{'{id: 4'h3, addr: 32'h0000_1000, len: 8'd3}};
    run_bursts("short burst");
  endtask

  task automatic split_burst();
    burst_q = '{'{id: 4'h5, addr: 32'h2000_0040, len: 8'd20}};
    run_bursts("split burst");
  endtask

  task automatic max_burst();
    burst_q = '{'{id: 4'h9, addr: 32'h8000_0000, len: 8'd255}};
    run_bursts("max burst");
  endtask

  task automatic back_to_back_backpressure();
    burst_q = '{'{id: 4'h1, addr: 32'h0000_0100, len: 8'd0},
                '{id: 4'h2, addr: 32'h0000_0200, len: 8'd7},
                '{id: 4'h4, addr: 32'h0000_0400, len: 8'd16},
                '{id: 4'h7, addr: 32'h0001_0000, len: 8'd33},
                '{id: 4'hc, addr: 32'h0002_0000, len: 8'd17}};
    rand_ready = 1'b1;
    run_bursts("back to back");
    rand_ready = 1'b0;
  endtask

  initial begin
    void'($urandom(39));
    ARESET     = 1'b1;
    s_aw       = '0;
    s_aw_valid = 1'b0;
    s_w        = '0;
    s_w_valid  = 1'b0;
    rand_ready = 1'b0;
    data_ctr   = 32'h0000_0100;   // counter pattern carried as write data.
    repeat (RESET_CYCLES) @(posedge ACLK);
    @(negedge ACLK);
    ARESET = 1'b0;
    reset_state();
    short_burst();
    split_burst();
    max_burst();
    back_to_back_backpressure();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/axi_chan_pkg.sv
verilog/conv_cmd_pkg.sv
verilog/aw_burst_splitter.sv
verilog/cmd_fifo.sv
verilog/w_axi3_conv.sv
verilog/axi4_to_axi3_wr.sv
dv/tb_axi4_to_axi3_wr.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the pass or fail result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_axi4_to_axi3_wr \
  -f list.f \
  -o tb_sim

./obj_dir/tb_sim

/* verilog/aw_burst_splitter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "axi_conv_consts.svh"

module aw_burst_splitter
  import axi_chan_pkg::*;
  import conv_cmd_pkg::*;
(
  input  logic     ACLK,
  input  logic     ARESET,
  input  axi4_aw_t s_aw,
  input  logic     s_aw_valid,
  output logic     s_aw_ready,
  output axi3_aw_t m_aw,
  output logic     m_aw_valid,
  input  logic     m_aw_ready,
  output logic     cmd_push,
  output wr_cmd_t  cmd,
  input  logic     cmd_full
);

  localparam logic [`AXI_ADDR_W-1:0] ADDR_STEP = `AXI3_MAX_BEATS * `AXI_STRB_W;

  split_state_t           state_q;
  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [7:0]             rem_q;      // beats left in the burst, minus one.
  logic                   last_piece;
  logic [3:0]             piece_len;
  logic                   aw_xfer;

  assign last_piece = (rem_q[7:4] == 4'd0);
  assign piece_len  = last_piece ? rem_q[3:0] : 4'd15;

  assign s_aw_ready = (state_q == SPLIT_IDLE);
  assign m_aw_valid = (state_q == SPLIT_BUSY) && !cmd_full; // never issue without a FIFO slot.
  assign aw_xfer    = m_aw_valid && m_aw_ready;
  assign cmd_push   = aw_xfer;

  assign m_aw.id     = id_q;
  assign m_aw.addr   = addr_q;
  assign m_aw.len    = piece_len;
  assign cmd.id      = id_q;
  assign cmd.length  = piece_len;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state_q <= SPLIT_IDLE;
    end else begin
      case (state_q)
        SPLIT_IDLE: begin
          if (s_aw_valid) begin
            state_q <= SPLIT_BUSY;
          end
        end
        SPLIT_BUSY: begin
          if (aw_xfer && last_piece) begin
            state_q <= SPLIT_IDLE;
          end
        end
        default: state_q <= SPLIT_IDLE;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (s_aw_valid && s_aw_ready) begin
      id_q   <= s_aw.id;
      addr_q <= s_aw.addr;
      rem_q  <= s_aw.len;
    end else if (aw_xfer && !last_piece) begin
      addr_q <= addr_q + ADDR_STEP;   // next piece starts 16 beats further on.
      rem_q  <= rem_q - 8'd16;
    end
  end

  // a stalled piece must stay offered unchanged, which relies on the FIFO never filling up
  // further while no push happens.
  a_m_aw_stable: assert property (
    @(posedge ACLK) disable iff (ARESET)
    m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw)
  ) else $error("m_aw changed or dropped while stalled.");

endmodule

`default_nettype wire

/* verilog/axi4_to_axi3_wr.sv */
`timescale 1ns/100ps
`default_nettype none

`include "axi_conv_consts.svh"

module axi4_to_axi3_wr
  import axi_chan_pkg::*;
  import conv_cmd_pkg::*;
(
  input  logic     ACLK,
  input  logic     ARESET,
  input  axi4_aw_t s_aw,
  input  logic     s_aw_valid,
  output logic     s_aw_ready,
  input  axi4_w_t  s_w,
  input  logic     s_w_valid,
  output logic     s_w_ready,
  output axi3_aw_t m_aw,
  output logic     m_aw_valid,
  input  logic     m_aw_ready,
  output axi3_w_t  m_w,
  output logic     m_w_valid,
  input  logic     m_w_ready
);

  logic    cmd_push;
  wr_cmd_t cmd_in;
  logic    cmd_full;
  logic    cmd_valid;
  logic    cmd_ready;
  wr_cmd_t cmd_head;

  aw_burst_splitter i_aw_burst_splitter (
    .ACLK       (ACLK),
    .ARESET     (ARESET),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .cmd_push   (cmd_push),
    .cmd        (cmd_in),
    .cmd_full   (cmd_full)
  );

  cmd_fifo i_cmd_fifo (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .push      (cmd_push),
    .push_data (cmd_in),
    .full      (cmd_full),
    .pop_valid (cmd_valid),
    .pop_data  (cmd_head),
    .pop_ready (cmd_ready)
  );

  w_axi3_conv i_w_axi3_conv (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .cmd       (cmd_head),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .s_w       (s_w),
    .s_w_valid (s_w_valid),
    .s_w_ready (s_w_ready),
    .m_w       (m_w),
    .m_w_valid (m_w_valid),
    .m_w_ready (m_w_ready)
  );

endmodule

`default_nettype wire

/* verilog/axi_chan_pkg.sv */
`default_nettype none

`include "axi_conv_consts.svh"

package axi_chan_pkg;

  // AXI4 write address payload; len is beats minus one.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
  } axi4_aw_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [3:0]             len;   // at most 16 beats per AXI3 burst.
  } axi3_aw_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi4_w_t;

  // AXI3 keeps WID on the data channel.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi3_w_t;

endpackage

`default_nettype wire

/* verilog/axi_conv_consts.svh */
`ifndef AXI_CONV_CONSTS_SVH
`define AXI_CONV_CONSTS_SVH

// Widths shared by the AXI4 slave side and the AXI3 master side.
`define AXI_ID_W 4
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W/8)

// AXI3 bursts are at most 16 beats.
`define AXI3_MAX_BEATS 16

// log2 of the number of piece commands held between the AW and W paths.
`define CMD_FIFO_AW 2

`endif

/* verilog/cmd_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "axi_conv_consts.svh"

module cmd_fifo
  import conv_cmd_pkg::*;
(
  input  logic    ACLK,
  input  logic    ARESET,
  input  logic    push,
  input  wr_cmd_t push_data,
  output logic    full,
  output logic    pop_valid,
  output wr_cmd_t pop_data,
  input  logic    pop_ready
);

  localparam int DEPTH = 2 ** `CMD_FIFO_AW;

  wr_cmd_t                mem [DEPTH];
  logic [`CMD_FIFO_AW:0]  wr_ptr_q;    // top bit flags a wrap of the pointer.
  logic [`CMD_FIFO_AW:0]  rd_ptr_q;
  logic                   empty;
  logic                   pop;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[`CMD_FIFO_AW] != rd_ptr_q[`CMD_FIFO_AW]) &&
                 (wr_ptr_q[`CMD_FIFO_AW-1:0] == rd_ptr_q[`CMD_FIFO_AW-1:0]);

  assign pop_valid = !empty;
  assign pop_data  = mem[rd_ptr_q[`CMD_FIFO_AW-1:0]];
  assign pop       = pop_valid && pop_ready;

  always_ff @(posedge ACLK) begin
    if (push) begin
      mem[wr_ptr_q[`CMD_FIFO_AW-1:0]] <= push_data;
    end
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // the splitter is expected to hold off while the FIFO is full.
  a_no_push_full: assert property (
    @(posedge ACLK) disable iff (ARESET)
    push |-> !full
  ) else $error("push into a full command FIFO.");

endmodule

`default_nettype wire

/* verilog/conv_cmd_pkg.sv */
`default_nettype none

`include "axi_conv_consts.svh"

package conv_cmd_pkg;

  // one AXI3 piece as seen by the data path.
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [3:0]           length;   // beats minus one.
  } wr_cmd_t;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_BUSY
  } split_state_t;

endpackage

`default_nettype wire

/* verilog/w_axi3_conv.sv */
`timescale 1ns/100ps
`default_nettype none

`include "axi_conv_consts.svh"

module w_axi3_conv
  import axi_chan_pkg::*;
  import conv_cmd_pkg::*;
(
  input  logic    ACLK,
  input  logic    ARESET,
  input  wr_cmd_t cmd,
  input  logic    cmd_valid,
  output logic    cmd_ready,
  input  axi4_w_t s_w,
  input  logic    s_w_valid,
  output logic    s_w_ready,
  output axi3_w_t m_w,
  output logic    m_w_valid,
  input  logic    m_w_ready
);

  logic       first_beat_q;
  logic [3:0] cnt_q;
  logic [3:0] cnt;
  logic       last_beat;
  logic       w_xfer;

  // the first beat of a piece takes its count straight from the command.
  assign cnt       = first_beat_q ? cmd.length : cnt_q;
  assign last_beat = (cnt == 4'd0);

  assign m_w_valid = s_w_valid && cmd_valid;
  assign s_w_ready = s_w_valid && cmd_valid && m_w_ready;
  assign w_xfer    = m_w_valid && m_w_ready;
  assign cmd_ready = w_xfer && last_beat;

  assign m_w.id   = cmd.id;
  assign m_w.data = s_w.data;
  assign m_w.strb = s_w.strb;
  assign m_w.last = last_beat;    // s_w.last is ignored; the count already knows.

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      first_beat_q <= 1'b1;
      cnt_q        <= 4'd0;
    end else if (w_xfer) begin
      first_beat_q <= last_beat;
      cnt_q        <= cnt - 4'd1;
    end
  end

  // Once a beat is offered, the command FIFO must keep its head until that beat goes.
  a_cmd_held: assert property (
    @(posedge ACLK) disable iff (ARESET)
    m_w_valid && !m_w_ready |=> cmd_valid
  ) else $error("command dropped under a stalled W beat.");

endmodule

`default_nettype wire
